// ==== rtl/load_pkg.sv ====
/*
 Download stream and RAM write definitions for the loader.
 Addresses are byte addresses. One RAM word holds two host half-words.
*/
package load_pkg;

	// ====================
	// Widths
	// ====================
	localparam int ADDR_W = 27;
	localparam int HALF_W = 16;
	localparam int WORD_W = 32;

	// Region being loaded, decoded from the download index
	typedef enum logic [1:0] {
		REGION_NONE,
		REGION_BIOS,
		REGION_EXE,
		REGION_CD
	} region_t;

	// Host download bundle
	typedef struct packed {
		logic              download;
		logic [7:0]        index;
		logic [ADDR_W-1:0] addr;
		logic [HALF_W-1:0] dout;
		logic              wr;
	} ioctl_t;

	// One 32-bit RAM write request
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [WORD_W-1:0] data;
		logic              wr;
	} ram_write_t;

	// End of a download and the region that just finished
	typedef struct packed {
		logic    valid;
		region_t region;
	} dl_end_t;

endpackage

// ==== rtl/media_pkg.sv ====
/*
 Image slot numbering and media state for the CD and memory cards.
 Bit 0 of the mount vector is not used by the loader.
*/
package media_pkg;

	// ====================
	// Mount vector
	// ====================
	localparam int IMG_N    = 4;
	localparam int SLOT_CD  = 1;
	localparam int SLOT_MC1 = 2;
	localparam int SLOT_MC2 = 3;

	// CD size in bytes, wide enough for a full disc image
	localparam int CD_SIZE_W = 30;

	// ====================
	// Media state
	// ====================
	// mc_available bit 0 is card 1, bit 1 is card 2
	typedef struct packed {
		logic                 has_cd;
		logic                 cd_from_sd;
		logic [CD_SIZE_W-1:0] cd_size;
		logic [1:0]           mc_available;
		logic                 cart_loaded;
	} media_status_t;

endpackage

// ==== rtl/download_fsm.sv ====
/*
 Host must hold download two cycles before its first write
 and must not write while ioctl_wait is high.
*/
`timescale 1ns/1ps

module download_fsm (
	input  logic              clk_1x,
	input  logic              rst,
	input  load_pkg::ioctl_t  ioctl,
	input  logic              ram_ack,
	output logic              ioctl_wait,
	output load_pkg::region_t region,
	output logic              lo_latch,
	output logic              hi_latch,
	output load_pkg::dl_end_t dl_end,
	output logic              exe_start
);
	import load_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_WAIT
	} state_t;

	state_t  state;
	region_t region_dec;
	region_t region_q;
	logic    accept;

	// ====================
	// Region decode
	// ====================
	// CD index may carry flags in the top two bits
	always_comb begin
		region_dec = REGION_NONE;
		if (ioctl.download) begin
			if (ioctl.index == 8'd0) begin
				region_dec = REGION_BIOS;
			end else if (ioctl.index == 8'd1) begin
				region_dec = REGION_EXE;
			end else if (ioctl.index[5:0] == 6'd2) begin
				region_dec = REGION_CD;
			end
		end
	end

	always_ff @(posedge clk_1x) begin
		if (rst) begin
			region    <= REGION_NONE;
			region_q  <= REGION_NONE;
			exe_start <= 1'b0;
		end else begin
			region    <= region_dec;
			region_q  <= region;
			exe_start <= dl_end.valid && (dl_end.region == REGION_EXE);
		end
	end

	// Falling edge of the registered region
	assign dl_end = '{valid: (region_q != REGION_NONE) && (region == REGION_NONE),
	                  region: region_q};

	// ====================
	// Write sequencing
	// ====================
	always_ff @(posedge clk_1x) begin
		if (rst) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (region_dec != REGION_NONE) begin
						state <= ST_LOAD;
					end
				end
				ST_LOAD: begin
					// A final high half still waits for its ack
					if (hi_latch) begin
						state <= ST_WAIT;
					end else if (region_dec == REGION_NONE) begin
						state <= ST_IDLE;
					end
				end
				ST_WAIT: begin
					if (region == REGION_NONE) begin
						state <= ST_IDLE;
					end else if (ram_ack) begin
						state <= (region_dec == REGION_NONE) ? ST_IDLE : ST_LOAD;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Address bit 1 picks the half of the word
	assign accept     = (state == ST_LOAD) && ioctl.wr;
	assign lo_latch   = accept && !ioctl.addr[1];
	assign hi_latch   = accept && ioctl.addr[1];
	assign ioctl_wait = (state == ST_WAIT);

	// Host back-pressure
	assert property (@(posedge clk_1x) disable iff (rst) ioctl_wait |-> !ioctl.wr)
		else $error("host write while ioctl_wait is high");

	// Every host write during a download lands as a half-word
	assert property (@(posedge clk_1x) disable iff (rst)
		(ioctl.download && ioctl.wr) |-> accept)
		else $error("host write before the loader was ready");

endmodule

// ==== rtl/ram_word_builder.sv ====
/*
 Packs two host half-words into one RAM write, low half first.
 BIOS_BASE and EXE_BASE must fit in ADDR_W bits.
*/
`timescale 1ns/1ps

module ram_word_builder #(
	parameter int unsigned BIOS_BASE = 2097152,
	parameter int unsigned EXE_BASE  = 4194304
) (
	input  logic                 clk_1x,
	input  logic                 rst,
	input  load_pkg::ioctl_t     ioctl,
	input  load_pkg::region_t    region,
	input  logic                 lo_latch,
	input  logic                 hi_latch,
	output load_pkg::ram_write_t ram
);
	import load_pkg::*;

	logic [ADDR_W-1:0] base;
	logic [ADDR_W-1:0] addr_q;
	logic [WORD_W-1:0] data_q;
	logic              wr_q;

	// CD images keep their raw address
	always_comb begin
		case (region)
			REGION_BIOS: base = ADDR_W'(BIOS_BASE);
			REGION_EXE:  base = ADDR_W'(EXE_BASE);
			default:     base = '0;
		endcase
	end

	// ====================
	// Word assembly
	// ====================
	always_ff @(posedge clk_1x) begin
		if (lo_latch) begin
			addr_q             <= ioctl.addr + base;
			data_q[HALF_W-1:0] <= ioctl.dout;
		end
		if (hi_latch) begin
			data_q[WORD_W-1:HALF_W] <= ioctl.dout;
		end
	end

	always_ff @(posedge clk_1x) begin
		if (rst) begin
			wr_q <= 1'b0;
		end else begin
			wr_q <= hi_latch;
		end
	end

	assign ram = '{addr: addr_q, data: data_q, wr: wr_q};

	// Wait from the FSM keeps writes apart
	assert property (@(posedge clk_1x) disable iff (rst) ram.wr |=> !ram.wr)
		else $error("RAM write strobe held for two cycles");

endmodule

// ==== rtl/media_tracker.sv ====
/*
 CD and memory-card image state with load and save requests.
 A mount strobe and the end of a CD download in one cycle favour the mount.
*/
`timescale 1ns/1ps

module media_tracker (
	input  logic                        clk_1x,
	input  logic                        rst,
	input  logic                        dl_end,
	input  load_pkg::region_t           region,
	input  logic [load_pkg::ADDR_W-1:0] last_addr,
	input  logic [media_pkg::IMG_N-1:0] img_mounted,
	input  logic [63:0]                 img_size,
	input  logic                        bk_load,
	input  logic                        bk_save,
	input  logic                        bk_autosave,
	input  logic                        osd_status,
	output media_pkg::media_status_t    media,
	output logic [1:0]                  mc_load,
	output logic                        mc_save
);
	import load_pkg::*;
	import media_pkg::*;

	logic       img_nonzero;
	logic [1:0] mc_mount;
	logic       cd_end;
	logic       cart_end;
	logic       save_auto;
	logic       load_q;
	logic       save_q;
	logic       save_auto_q;
	logic       load_rise;
	logic       save_rise;

	assign img_nonzero = (img_size != 64'd0);
	assign mc_mount    = {img_mounted[SLOT_MC2], img_mounted[SLOT_MC1]};
	assign cd_end      = dl_end && (region == REGION_CD);
	assign cart_end    = dl_end && ((region == REGION_CD) || (region == REGION_EXE));

	// Autosave fires when the OSD opens
	assign save_auto = osd_status & bk_autosave;
	assign load_rise = bk_load & ~load_q;
	assign save_rise = (bk_save & ~save_q) | (save_auto & ~save_auto_q);

	// ====================
	// Button edges
	// ====================
	always_ff @(posedge clk_1x) begin
		if (rst) begin
			load_q      <= 1'b0;
			save_q      <= 1'b0;
			save_auto_q <= 1'b0;
			mc_load     <= 2'b00;
			mc_save     <= 1'b0;
		end else begin
			load_q      <= bk_load;
			save_q      <= bk_save;
			save_auto_q <= save_auto;
			// Mounted card reloads, button reloads both
			mc_load     <= (mc_mount & {2{img_nonzero}}) | {2{load_rise}};
			mc_save     <= save_rise;
		end
	end

	// ====================
	// Media state
	// ====================
	always_ff @(posedge clk_1x) begin
		if (rst) begin
			media <= '0;
		end else begin
			// Downloaded CD lives in RAM
			if (cd_end) begin
				media.cd_size    <= CD_SIZE_W'(last_addr);
				media.has_cd     <= 1'b1;
				media.cd_from_sd <= 1'b0;
			end

			if (img_mounted[SLOT_CD]) begin
				if (img_nonzero) begin
					media.cd_size    <= img_size[CD_SIZE_W-1:0];
					media.has_cd     <= 1'b1;
					media.cd_from_sd <= 1'b1;
				end else begin
					media.has_cd <= 1'b0;
				end
			end

			// Empty mount unplugs the card
			media.mc_available <= (media.mc_available & ~mc_mount)
			                    | (mc_mount & {2{img_nonzero}});

			if (img_mounted[SLOT_CD] || cart_end) begin
				media.cart_loaded <= 1'b1;
			end
		end
	end

endmodule

// ==== rtl/psx_loader.sv ====
/*
 Loader top level. All inputs are synchronous to clk_1x.
 ram_ack answers each RAM write once.
*/
`timescale 1ns/1ps

module psx_loader #(
	parameter int unsigned BIOS_BASE = 2097152,
	parameter int unsigned EXE_BASE  = 4194304
) (
	input  logic                        clk_1x,
	input  logic                        rst,
	input  load_pkg::ioctl_t            ioctl,
	input  logic                        ram_ack,
	input  logic [media_pkg::IMG_N-1:0] img_mounted,
	input  logic [63:0]                 img_size,
	input  logic                        bk_load,
	input  logic                        bk_save,
	input  logic                        bk_autosave,
	input  logic                        osd_status,
	output logic                        ioctl_wait,
	output load_pkg::ram_write_t        ram,
	output logic                        exe_start,
	output media_pkg::media_status_t    media,
	output logic [1:0]                  mc_load,
	output logic                        mc_save
);
	import load_pkg::*;

	region_t region;
	logic    lo_latch;
	logic    hi_latch;
	dl_end_t dl_end;

	download_fsm u_download_fsm (
		.clk_1x     (clk_1x),
		.rst        (rst),
		.ioctl      (ioctl),
		.ram_ack    (ram_ack),
		.ioctl_wait (ioctl_wait),
		.region     (region),
		.lo_latch   (lo_latch),
		.hi_latch   (hi_latch),
		.dl_end     (dl_end),
		.exe_start  (exe_start)
	);

	ram_word_builder #(
		.BIOS_BASE (BIOS_BASE),
		.EXE_BASE  (EXE_BASE)
	) u_ram_word_builder (
		.clk_1x   (clk_1x),
		.rst      (rst),
		.ioctl    (ioctl),
		.region   (region),
		.lo_latch (lo_latch),
		.hi_latch (hi_latch),
		.ram      (ram)
	);

	// Host keeps the last address after download drops
	media_tracker u_media_tracker (
		.clk_1x      (clk_1x),
		.rst         (rst),
		.dl_end      (dl_end.valid),
		.region      (dl_end.region),
		.last_addr   (ioctl.addr),
		.img_mounted (img_mounted),
		.img_size    (img_size),
		.bk_load     (bk_load),
		.bk_save     (bk_save),
		.bk_autosave (bk_autosave),
		.osd_status  (osd_status),
		.media       (media),
		.mc_load     (mc_load),
		.mc_save     (mc_save)
	);

endmodule

// ==== tb/tb_psx_loader.sv ====
/*
 Runs records from tb/psx_loader_golden.txt; start from the project root.
 Expected addresses assume BIOS base 0x200000 and executable base 0x400000.
*/
`timescale 1ns/1ps

module tb_psx_loader;
	import load_pkg::*;
	import media_pkg::*;

	localparam int WAIT_LIMIT = 50;
	localparam int NAME_W     = 8 * 24;

	logic              clk_1x;
	logic              rst;
	ioctl_t            ioctl;
	logic              ram_ack;
	logic [IMG_N-1:0]  img_mounted;
	logic [63:0]       img_size;
	logic              bk_load;
	logic              bk_save;
	logic              bk_autosave;
	logic              osd_status;
	logic              ioctl_wait;
	ram_write_t        ram;
	logic              exe_start;
	media_status_t     media;
	logic [1:0]        mc_load;
	logic              mc_save;

	// Current record
	logic [NAME_W-1:0] test_name;
	logic [NAME_W-1:0] op;
	logic [63:0]       field [5];

	int unsigned       lcg_state;
	int                errors;
	int                timeouts;
	int                checks;
	int                exe_count;
	int                save_count;

	psx_loader #(
		.BIOS_BASE (2097152),
		.EXE_BASE  (4194304)
	) UUT (
		.clk_1x      (clk_1x),
		.rst         (rst),
		.ioctl       (ioctl),
		.ram_ack     (ram_ack),
		.img_mounted (img_mounted),
		.img_size    (img_size),
		.bk_load     (bk_load),
		.bk_save     (bk_save),
		.bk_autosave (bk_autosave),
		.osd_status  (osd_status),
		.ioctl_wait  (ioctl_wait),
		.ram         (ram),
		.exe_start   (exe_start),
		.media       (media),
		.mc_load     (mc_load),
		.mc_save     (mc_save)
	);

	always #20 clk_1x = ~clk_1x;

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	// ====================
	// Helpers
	// ====================
	// Outputs are all registered, so sample and drive share this point
	task automatic next_cycle();
		@(posedge clk_1x);
		#2;
	endtask

	task automatic check(input string what, input logic [63:0] expected,
	                     input logic [63:0] actual);
		checks++;
		if (expected !== actual) begin
			$display("CHECK FAILED %0s %0s: expected %0h, actual %0h",
			         test_name, what, expected, actual);
			errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout: %0s did not come within %0d cycles in test %0s",
		         what, WAIT_LIMIT, test_name);
		timeouts++;
	endtask

	task automatic write_half(input logic [ADDR_W-1:0] addr, input logic [HALF_W-1:0] data);
		ioctl.addr = addr;
		ioctl.dout = data;
		ioctl.wr   = 1'b1;
		next_cycle();
		ioctl.wr   = 1'b0;
	endtask

	// Counts exe_start and mc_save pulses over a window
	task automatic watch(input int cycles);
		exe_count  = 0;
		save_count = 0;
		repeat (cycles) begin
			next_cycle();
			if (exe_start) begin
				exe_count++;
			end
			if (mc_save) begin
				save_count++;
			end
		end
	endtask

	task automatic write_pair();
		int n;
		int delay;
		n     = 0;
		delay = int'(lcg_next() % 32'd6);
		write_half(field[0][ADDR_W-1:0], field[1][HALF_W-1:0]);
		write_half(field[0][ADDR_W-1:0] + ADDR_W'(2), field[2][HALF_W-1:0]);
		while (!ram.wr && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (!ram.wr) begin
			report_timeout("RAM write strobe");
		end else begin
			check("ram.addr", field[3], 64'(ram.addr));
			check("ram.data", field[4], 64'(ram.data));
			// Host is held off until the RAM answers
			repeat (delay) begin
				check("ioctl_wait before ack", 64'd1, 64'(ioctl_wait));
				next_cycle();
			end
			check("ioctl_wait before ack", 64'd1, 64'(ioctl_wait));
			ram_ack = 1'b1;
			next_cycle();
			ram_ack = 1'b0;
			n = 0;
			while (ioctl_wait && n < WAIT_LIMIT) begin
				next_cycle();
				n++;
			end
			if (ioctl_wait) begin
				report_timeout("ioctl_wait release after ram_ack");
			end
		end
	endtask

	// ====================
	// Record dispatch
	// ====================
	task automatic run_record();
		if (op == "START") begin
			ioctl.download = 1'b1;
			ioctl.index    = field[0][7:0];
			ioctl.addr     = '0;
			next_cycle();
			next_cycle();
		end else if (op == "PAIR") begin
			write_pair();
		end else if (op == "END") begin
			ioctl.download = 1'b0;
			watch(8);
			check("exe_start pulses", field[3], 64'(exe_count));
			check("ioctl_wait after end", 64'd0, 64'(ioctl_wait));
		end else if (op == "MEDIA") begin
			next_cycle();
			check("has_cd", field[0], 64'(media.has_cd));
			check("cd_from_sd", field[1], 64'(media.cd_from_sd));
			check("cd_size", field[2], 64'(media.cd_size));
			check("mc_available", field[3], 64'(media.mc_available));
			check("cart_loaded", field[4], 64'(media.cart_loaded));
		end else if (op == "MOUNT") begin
			img_mounted[field[0][1:0]] = 1'b1;
			img_size                   = field[1];
			next_cycle();
			check("mc_load", field[3], 64'(mc_load));
			img_mounted = '0;
			img_size    = '0;
			next_cycle();
			check("mc_load after pulse", 64'd0, 64'(mc_load));
		end else if (op == "LOAD") begin
			bk_load = 1'b1;
			next_cycle();
			check("mc_load", field[3], 64'(mc_load));
			bk_load = 1'b0;
			next_cycle();
			check("mc_load after pulse", 64'd0, 64'(mc_load));
		end else if (op == "SAVE") begin
			bk_save = 1'b1;
			watch(4);
			check("mc_save pulses", field[3], 64'(save_count));
			bk_save = 1'b0;
			next_cycle();
		end else if (op == "OSD") begin
			bk_autosave = field[0][0];
			osd_status  = 1'b1;
			watch(4);
			check("mc_save pulses", field[3], 64'(save_count));
			osd_status  = 1'b0;
			bk_autosave = 1'b0;
			next_cycle();
		end else begin
			$display("Unknown operation in golden file for test %0s", test_name);
			errors++;
		end
	endtask

	initial begin
		int                 fd;
		int                 n;
		int                 records;
		logic [8*128-1:0]   line;
		clk_1x      = 1'b0;
		rst         = 1'b1;
		ioctl       = '0;
		ram_ack     = 1'b0;
		img_mounted = '0;
		img_size    = '0;
		bk_load     = 1'b0;
		bk_save     = 1'b0;
		bk_autosave = 1'b0;
		osd_status  = 1'b0;
		lcg_state   = 32'd50;
		errors      = 0;
		timeouts    = 0;
		checks      = 0;
		records     = 0;
		next_cycle();
		next_cycle();
		rst = 1'b0;

		fd = $fopen("tb/psx_loader_golden.txt", "r");
		if (fd == 0) begin
			$display("Cannot open golden file tb/psx_loader_golden.txt");
			errors++;
		end else begin
			while (!$feof(fd) && timeouts == 0) begin
				line = '0;
				if ($fgets(line, fd) > 0) begin
					test_name = '0;
					op        = '0;
					n = $sscanf(line, "%s %s %h %h %h %h %h", test_name, op,
					            field[0], field[1], field[2], field[3], field[4]);
					if (n == 7) begin
						records++;
						run_record();
					end else if (n > 0 && test_name != "#") begin
						$display("Malformed line in golden file near test %0s", test_name);
						errors++;
					end
				end
			end
			$fclose(fd);
			if (records == 0) begin
				$display("No records were read from the golden file");
				errors++;
			end
		end

		$display("Errors: %0d mismatches, %0d timeouts in %0d checks",
		         errors, timeouts, checks);
		if (errors == 0 && timeouts == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// ==== psx_loader.f ====
rtl/load_pkg.sv
rtl/media_pkg.sv
rtl/download_fsm.sv
rtl/ram_word_builder.sv
rtl/media_tracker.sv
rtl/psx_loader.sv
tb/tb_psx_loader.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the psx_loader testbench with Verilator.
# Run from any directory; paths are resolved from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_psx_loader -f psx_loader.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

if [ ! -x ./obj_dir/Vtb_psx_loader ]; then
	echo "Simulation binary not found"
	exit 1
fi

output=$(./obj_dir/Vtb_psx_loader)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Finished with no errors"; then
	exit 0
fi
exit 1

// ==== tb/psx_loader_golden.txt ====
# name op a b c d e, all numbers in hex
# a..c are operands, d and e expected values (MEDIA: all five expected)
reset_media      MEDIA 0 0 0 0 0
bios_start       START 0 0 0 0 0
bios_w0          PAIR 0 1234 abcd 200000 abcd1234
bios_w1          PAIR 4 5678 9abc 200004 9abc5678
bios_w2          PAIR 100 dead beef 200100 beefdead
bios_end         END 0 0 0 0 0
bios_media       MEDIA 0 0 0 0 0
exe_start        START 1 0 0 0 0
exe_w0           PAIR 0 0001 8000 400000 80000001
exe_w1           PAIR 7ff0 55aa a55a 407ff0 a55a55aa
exe_end          END 0 0 0 1 0
exe_media        MEDIA 0 0 0 0 1
cd_start         START 42 0 0 0 0
cd_w0            PAIR 0 1111 2222 0 22221111
cd_w1            PAIR 123458 cafe f00d 123458 f00dcafe
cd_end           END 0 0 0 0 0
cd_media         MEDIA 1 0 12345a 0 1
cd_mount         MOUNT 1 2468ace 0 0 0
cd_mount_media   MEDIA 1 1 2468ace 0 1
cd_unmount       MOUNT 1 0 0 0 0
cd_unmount_media MEDIA 0 1 2468ace 0 1
mc1_mount        MOUNT 2 20000 0 1 0
mc2_mount        MOUNT 3 20000 0 2 0
mc_media         MEDIA 0 1 2468ace 3 1
mc1_unmount      MOUNT 2 0 0 0 0
mc1_off_media    MEDIA 0 1 2468ace 2 1
btn_load         LOAD 0 0 0 3 0
btn_save         SAVE 0 0 0 1 0
osd_auto         OSD 1 0 0 1 0
osd_manual       OSD 0 0 0 0 0
